// File: all.f
noc_flit_pkg.sv
noc_route_pkg.sv
noc_buffer.sv
noc_route_decode.sv
noc_output_arbiter.sv
noc_router.sv
tb_noc_router.sv

// File: noc_buffer.sv
`timescale 1ns/100ps

module noc_buffer #(
   parameter int DEPTH      = 8,
   parameter int FULLPACKET = 0
) (
   input  logic                    clk,
   input  logic                    rst,

   // write side
   input  noc_flit_pkg::noc_flit_t in_flit,
   input  logic                    in_valid,
   output logic                    in_ready,

   // read side, head of the fifo
   output noc_flit_pkg::noc_flit_t out_flit,
   output logic                    out_valid,
   input  logic                    out_ready,

   output noc_route_pkg::pkt_len_t packet_size  // oldest complete packet
);

   localparam int              id_w    = $clog2(DEPTH);
   localparam logic [id_w-1:0] top_idx = id_w'(DEPTH - 1);

   // shift register, newest entry at index 0
   noc_flit_pkg::noc_flit_t [DEPTH-1:0] mem;
   logic [id_w-1:0]                     rp;      // index of the oldest entry
   logic                                filled;  // at least one entry in use
   logic                                in_fire;
   logic                                out_fire;

   // full only when rp sits at the top and that entry is live
   assign in_ready = (rp != top_idx) || !filled;
   assign in_fire  = in_valid && in_ready;
   assign out_fire = out_valid && out_ready;
   assign out_flit = mem[rp];

   always_ff @(posedge clk) begin
      if (rst) begin
         filled <= 1'b0;
      end else if (in_fire) begin
         filled <= 1'b1;
      end else if (out_fire && rp == '0) begin
         filled <= 1'b0;  // last entry popped
      end
   end

   // push without pop moves the head one deeper, pop alone pulls it back
   always_ff @(posedge clk) begin
      if (rst) begin
         rp <= '0;
      end else if (in_fire && !out_fire && filled) begin
         rp <= rp + 1'b1;
      end else if (out_fire && !in_fire && rp != '0) begin
         rp <= rp - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (in_fire) begin
         mem <= {mem[DEPTH-2:0], in_flit};
      end
   end

   generate
      if (FULLPACKET != 0) begin : g_full
         logic [DEPTH-1:0] last_buf;   // last flags, shifted like mem
         logic [DEPTH-1:0] last_live;  // live flags, oldest entry at the top bit

         always_ff @(posedge clk) begin
            if (rst) begin
               last_buf <= '0;
            end else if (in_fire) begin
               last_buf <= {last_buf[DEPTH-2:0], in_flit.last};
            end
         end

         // drop the stale entries below the head
         assign last_live = last_buf << (top_idx - rp);

         // highest set bit is the first last flag behind the head
         always_comb begin
            packet_size = '0;
            for (int k = 0; k < DEPTH; k++) begin
               if (filled && last_live[k]) begin
                  packet_size = noc_route_pkg::pkt_len_t'(DEPTH - k);
               end
            end
         end

         assign out_valid = filled && (|last_live);  // hold until a packet is whole
      end else begin : g_flow
         assign packet_size = '0;
         assign out_valid   = filled;  // cut through flit by flit
      end
   endgenerate

endmodule

// File: noc_flit_pkg.sv
package noc_flit_pkg;

   // flit data width, header and raw views share it
   localparam int flit_width = 32;

   // header flit view, dest sits in the top bits
   typedef struct packed {
      logic [4:0]  dest;   // destination node id
      logic [4:0]  src;    // source node id
      logic [1:0]  kind;   // packet class
      logic [19:0] spare;  // free for higher layers
   } noc_hdr_t;

   // one flit word, read as header by decode
   // and as plain payload by buffer and arbiter
   typedef union packed {
      noc_hdr_t                hdr;
      logic [flit_width-1:0]   raw;
   } noc_word_u;

   // unit stored in the buffers, 33 bits
   typedef struct packed {
      noc_word_u  data;
      logic       last;  // closes the packet
   } noc_flit_t;

endpackage

// File: noc_output_arbiter.sv
`timescale 1ns/100ps

module noc_output_arbiter (
   input  logic                          clk,
   input  logic                          rst,

   // both inputs, flit and request
   input  noc_flit_pkg::noc_flit_t [1:0] req_flit,
   input  logic [1:0]                    req,
   output logic [1:0]                    gnt_ready,  // ready back to the granted input

   // output port
   output noc_flit_pkg::noc_flit_t       out_flit,
   output logic                          out_valid,
   input  logic                          out_ready
);

   logic prio;      // input favored when idle
   logic locked;    // packet in flight
   logic lock_sel;  // owner of the output while locked
   logic sel;       // input switched to the output
   logic active;    // selected input has a flit
   logic fire;

   // grant is combinational so an idle output passes the flit at once
   always_comb begin
      if (locked) begin
         sel    = lock_sel;  // only the owner may send
         active = req[lock_sel];
      end else if (req[prio]) begin
         sel    = prio;
         active = 1'b1;
      end else begin
         sel    = ~prio;     // other input, if it asks
         active = req[~prio];
      end
   end

   assign out_flit  = req_flit[sel];
   assign out_valid = active;
   assign fire      = active && out_ready;

   always_comb begin
      gnt_ready      = '0;
      gnt_ready[sel] = fire;  // nobody else moves
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         prio     <= 1'b0;
         locked   <= 1'b0;
         lock_sel <= 1'b0;
      end else if (fire) begin
         if (req_flit[sel].last) begin
            locked <= 1'b0;
            prio   <= ~sel;  // winner goes behind
         end else if (!locked) begin
            locked   <= 1'b1;  // header of a multi flit packet
            lock_sel <= sel;
         end
      end
   end

endmodule

// File: noc_route_decode.sv
`timescale 1ns/100ps

module noc_route_decode #(
   parameter noc_route_pkg::node_id_t LOCAL_ID = 5'd3
) (
   input  logic                    clk,
   input  logic                    rst,

   // head of the input buffer
   input  noc_flit_pkg::noc_flit_t head_flit,
   input  logic                    head_valid,
   input  logic                    head_fire,  // head flit leaves this cycle

   output logic                    route_valid,
   output noc_route_pkg::out_sel_t route
);

   noc_flit_pkg::noc_hdr_t  hdr;
   noc_route_pkg::out_sel_t hdr_route;   // route of the current head, if header
   noc_route_pkg::out_sel_t held_route;  // route for body flits
   logic                    expect_hdr;  // next flit opens a packet

   // same word seen through the header view
   assign hdr = head_flit.data.hdr;

   // own id ejects locally, all else moves on
   assign hdr_route = (hdr.dest == LOCAL_ID) ? noc_route_pkg::sel_local
                                             : noc_route_pkg::sel_fwd;

   // header comes next after reset and after every last flit
   always_ff @(posedge clk) begin
      if (rst) begin
         expect_hdr <= 1'b1;
      end else if (head_fire) begin
         expect_hdr <= head_flit.last;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         held_route <= noc_route_pkg::sel_local;
      end else if (head_fire && expect_hdr) begin
         held_route <= hdr_route;  // kept for the body
      end
   end

   assign route_valid = head_valid;
   assign route       = expect_hdr ? hdr_route : held_route;

endmodule

// File: noc_route_pkg.sv
package noc_route_pkg;

   // node id, same width as the header dest field
   typedef logic [4:0] node_id_t;

   // output select of a packet
   typedef logic out_sel_t;

   localparam out_sel_t sel_local = 1'b0;  // port 0, ejects here
   localparam out_sel_t sel_fwd   = 1'b1;  // port 1, on to the next node

   // packet length in flits
   typedef logic [4:0] pkt_len_t;

endpackage

// File: noc_router.sv
`timescale 1ns/100ps

module noc_router #(
   parameter int                      DEPTH      = 8,
   parameter int                      FULLPACKET = 0,
   parameter noc_route_pkg::node_id_t LOCAL_ID   = 5'd3
) (
   input  logic                          clk,
   input  logic                          rst,

   input  noc_flit_pkg::noc_flit_t [1:0] in_flit,
   input  logic [1:0]                    in_valid,
   output logic [1:0]                    in_ready,

   // port 0 local, port 1 forward
   output noc_flit_pkg::noc_flit_t [1:0] out_flit,
   output logic [1:0]                    out_valid,
   input  logic [1:0]                    out_ready
);

   noc_flit_pkg::noc_flit_t [1:0] buf_flit;  // buffer heads
   logic [1:0]                    buf_valid;
   logic [1:0]                    buf_ready;
   logic [1:0]                    head_fire;
   logic [1:0]                    route_valid;
   noc_route_pkg::out_sel_t [1:0] route;
   logic [1:0][1:0]               req;  // [output][input]
   logic [1:0][1:0]               gnt;  // [output][input]

   for (genvar i = 0; i < 2; i++) begin : g_in
      noc_buffer #(
         .DEPTH      (DEPTH),
         .FULLPACKET (FULLPACKET)
      ) u_buffer (
         .clk         (clk),
         .rst         (rst),
         .in_flit     (in_flit[i]),
         .in_valid    (in_valid[i]),
         .in_ready    (in_ready[i]),
         .out_flit    (buf_flit[i]),
         .out_valid   (buf_valid[i]),
         .out_ready   (buf_ready[i]),
         .packet_size ()
      );

      // at most one output asks for this input
      assign buf_ready[i] = gnt[0][i] | gnt[1][i];
      assign head_fire[i] = buf_valid[i] & buf_ready[i];

      noc_route_decode #(
         .LOCAL_ID (LOCAL_ID)
      ) u_decode (
         .clk         (clk),
         .rst         (rst),
         .head_flit   (buf_flit[i]),
         .head_valid  (buf_valid[i]),
         .head_fire   (head_fire[i]),
         .route_valid (route_valid[i]),
         .route       (route[i])
      );
   end

   for (genvar j = 0; j < 2; j++) begin : g_out
      for (genvar i = 0; i < 2; i++) begin : g_req
         assign req[j][i] = route_valid[i] && (route[i] == noc_route_pkg::out_sel_t'(j));
      end

      noc_output_arbiter u_arbiter (
         .clk       (clk),
         .rst       (rst),
         .req_flit  (buf_flit),
         .req       (req[j]),
         .gnt_ready (gnt[j]),
         .out_flit  (out_flit[j]),
         .out_valid (out_valid[j]),
         .out_ready (out_ready[j])
      );
   end

endmodule

// File: noc_router_cases.txt
// columns: input port, destination id, length in flits (header included), first payload word
// payload flit k carries first word + k, the ff line closes the list
0 03 4 a0000100
1 03 5 b0000100
0 07 3 a0000200
1 0c 6 b0000200
0 03 1 a0000300
1 03 8 b0000300
0 1f 2 a0000400
1 00 4 b0000400
0 03 7 a0000500
1 03 3 b0000500
0 03 5 a0000600
1 05 5 b0000600
0 02 8 a0000700
1 02 2 b0000700
0 03 2 a0000800
1 03 6 b0000800
0 11 4 a0000900
1 03 1 b0000900
0 03 3 a0000a00
1 09 7 b0000a00
ff 00 00 00000000

// File: run_sim.sh
#!/bin/sh
# build the router testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --top-module tb_noc_router -f all.f > build.log 2>&1 \
   || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_noc_router > sim.log 2>&1
cat sim.log
grep -q "Simulation FAILED" sim.log && { echo "test failed"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "run ended without a verdict"; exit 1; }
echo "test passed"

// File: tb_noc_router.sv
`timescale 1ns/100ps

module tb_noc_router;

   localparam int                      DEPTH       = 8;
   localparam int                      FULLPACKET  = 1;
   localparam noc_route_pkg::node_id_t LOCAL_ID    = 5'd3;
   localparam int                      MAX_CASES   = 32;
   localparam int                      FLIT_LIMIT  = 200;   // cycles one flit may wait
   localparam int                      DRAIN_LIMIT = 2000;

   logic                          clk = 1'b0;
   logic                          rst;
   noc_flit_pkg::noc_flit_t [1:0] in_flit;
   logic [1:0]                    in_valid;
   logic [1:0]                    in_ready;
   noc_flit_pkg::noc_flit_t [1:0] out_flit;
   logic [1:0]                    out_valid;
   logic [1:0]                    out_ready  = 2'b00;
   int                            stall_mode = 0;  // 0 off, 1 random stalls, 2 always ready
   integer                        seed       = 32'h47968040;

   noc_flit_pkg::noc_flit_t drv_flit [2];  // one driver per input
   logic                    drv_valid [2];

   // cases as read from the file
   logic [31:0]             case_mem [0:4*MAX_CASES-1];
   int                      n_cases;
   int                      c_port [MAX_CASES];
   noc_route_pkg::node_id_t c_dest [MAX_CASES];
   noc_route_pkg::pkt_len_t c_len  [MAX_CASES];
   logic [31:0]             c_word [MAX_CASES];

   // expected traffic indexed by out*2 + in
   noc_flit_pkg::noc_flit_t exp_flit [4][$];
   noc_route_pkg::pkt_len_t exp_len  [4][$];
   int                      exp_case [4][$];
   int                      pkt_in   [4] = '{0, 0, 0, 0};  // packets fully entered
   int                      hdr_seen [4] = '{0, 0, 0, 0};  // headers already sent out

   logic                    in_hdr   [2] = '{1'b1, 1'b1};  // next input flit opens a packet
   int                      in_out   [2] = '{0, 0};        // port of the packet now entering
   logic                    mon_busy [2] = '{1'b0, 1'b0};  // output inside a packet
   int                      mon_src  [2] = '{0, 0};
   noc_route_pkg::pkt_len_t mon_cnt  [2] = '{5'd0, 5'd0};

   assign in_flit  = {drv_flit[1], drv_flit[0]};
   assign in_valid = {drv_valid[1], drv_valid[0]};

   always #4 clk = ~clk;  // 8 ns period

   noc_router #(
      .DEPTH      (DEPTH),
      .FULLPACKET (FULLPACKET),
      .LOCAL_ID   (LOCAL_ID)
   ) UUT (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (in_flit),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_flit  (out_flit),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   // own id ejects on port 0 and all else leaves on port 1
   function automatic int out_port(input noc_route_pkg::node_id_t dest);
      if (dest == LOCAL_ID) begin
         return 0;
      end
      return 1;
   endfunction

   // flit f of case n where f = 0 is the header
   function automatic noc_flit_pkg::noc_flit_t make_flit(input int n, input int f);
      noc_flit_pkg::noc_flit_t fl;
      fl = '0;
      if (f == 0) begin
         fl.data.hdr.dest  = c_dest[n];
         fl.data.hdr.src   = noc_route_pkg::node_id_t'(c_port[n]);  // input port as source
         fl.data.hdr.kind  = 2'b01;
         fl.data.hdr.spare = c_word[n][19:0];
      end else begin
         fl.data.raw = c_word[n] + 32'(f - 1);  // payload k is first word + k
      end
      fl.last = (f == int'(c_len[n]) - 1);
      return fl;
   endfunction

   task automatic abort_run();
      $display("Simulation FAILED");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic check_flit(input string name, input noc_flit_pkg::noc_flit_t exp,
                             input noc_flit_pkg::noc_flit_t got);
      if (got !== exp) begin
         $display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
         abort_run();
      end
   endtask

   task automatic check_len(input string name, input noc_route_pkg::pkt_len_t exp,
                            input noc_route_pkg::pkt_len_t got);
      if (got !== exp) begin
         $display("error at %0t ns: %s expected %0d got %0d", $time, name, exp, got);
         abort_run();
      end
   endtask

   task automatic expect_bits(input string name, input logic [1:0] exp, input logic [1:0] got);
      if (got !== exp) begin
         $display("error at %0t ns: %s expected %b got %b", $time, name, exp, got);
         abort_run();
      end
   endtask

   task automatic load_cases();
      int   n;
      int   f;
      int   q;
      logic done;
      $readmemh("noc_router_cases.txt", case_mem);
      n    = 0;
      done = 1'b0;
      while (!done) begin
         if (n == MAX_CASES) begin
            $display("case file has no end marker within %0d cases", MAX_CASES);
            abort_run();
         end else if (case_mem[4*n] == 32'hff) begin
            done = 1'b1;  // end marker
         end else if (case_mem[4*n] > 1 || case_mem[4*n+2] == 0 || case_mem[4*n+2] > DEPTH) begin
            $display("case %0d in the case file has a bad port or length", n);
            abort_run();
         end else begin
            c_port[n] = int'(case_mem[4*n]);
            c_dest[n] = case_mem[4*n+1][4:0];
            c_len[n]  = case_mem[4*n+2][4:0];
            c_word[n] = case_mem[4*n+3];
            q = 2 * out_port(c_dest[n]) + c_port[n];
            for (f = 0; f < int'(c_len[n]); f++) begin
               exp_flit[q].push_back(make_flit(n, f));
            end
            exp_len[q].push_back(c_len[n]);
            exp_case[q].push_back(n);
            n++;
         end
      end
      n_cases = n;
      if (n_cases == 0) begin
         $display("case file holds no packets");
         abort_run();
      end
   endtask

   // all packets of one input in file order
   task automatic send_packets(input int port);
      int   n;
      int   f;
      int   gap;
      int   waited;
      logic accepted;
      for (n = 0; n < n_cases; n++) begin
         if (c_port[n] == port) begin
            for (f = 0; f < int'(c_len[n]); f++) begin
               if (f > 0 && f == int'(c_len[n]) - 1) begin
                  gap = 2 + ($random(seed) & 3);  // last flit held back a while
               end else begin
                  gap = (($random(seed) & 3) == 0) ? 1 : 0;
               end
               repeat (gap) begin
                  @(posedge clk);
                  #1;
               end
               drv_flit[port]  = make_flit(n, f);
               drv_valid[port] = 1'b1;
               accepted = 1'b0;
               waited   = 0;
               while (!accepted) begin
                  @(negedge clk);
                  accepted = in_ready[port];  // transfer on the coming edge
                  @(posedge clk);
                  #1;
                  waited++;
                  if (!accepted && waited > FLIT_LIMIT) begin
                     $display("input %0d stuck, flit %0d of case %0d never accepted",
                              port, f, n);
                     abort_run();
                  end
               end
               drv_valid[port] = 1'b0;
            end
         end
      end
   endtask

   function automatic logic all_drained();
      logic empty;
      int   q;
      empty = !mon_busy[0] && !mon_busy[1];
      for (q = 0; q < 4; q++) begin
         if (exp_flit[q].size() != 0) begin
            empty = 1'b0;
         end
      end
      return empty;
   endfunction

   task automatic report_missing();
      int q;
      for (q = 0; q < 4; q++) begin
         if (exp_case[q].size() != 0) begin
            $display("case %0d from input %0d to output %0d never arrived in full",
                     exp_case[q][0], q % 2, q / 2);
         end
      end
   endtask

   // output back-pressure
   always @(posedge clk) begin
      #1;
      if (stall_mode == 1) begin
         out_ready[0] = (($random(seed) & 3) != 0);
         out_ready[1] = (($random(seed) & 3) != 0);
      end else if (stall_mode == 2) begin
         out_ready = 2'b11;
      end else begin
         out_ready = 2'b00;
      end
   end

   // monitor sampling mid cycle while everything is settled
   always @(negedge clk) begin
      int                      j;
      int                      i;
      int                      q;
      int                      cn;
      noc_flit_pkg::noc_flit_t got;
      if (!rst) begin
         for (j = 0; j < 2; j++) begin
            if (out_valid[j] && !mon_busy[j]) begin
               q = 2 * j + int'(out_flit[j].data.hdr.src[0]);
               if (exp_flit[q].size() == 0) begin
                  $display("output %0d shows a packet from input %0d that no case sends there",
                           j, q % 2);
                  abort_run();
               end else if (hdr_seen[q] >= pkt_in[q]) begin
                  $display("output %0d shows a header from input %0d before its last flit entered",
                           j, q % 2);
                  abort_run();
               end
            end
            if (out_valid[j] && out_ready[j]) begin
               got = out_flit[j];
               if (!mon_busy[j]) begin
                  mon_busy[j] = 1'b1;  // header locks onto its source
                  mon_src[j]  = int'(got.data.hdr.src[0]);
                  mon_cnt[j]  = '0;
                  hdr_seen[2*j + mon_src[j]]++;
               end
               // a foreign flit inside a packet misses the locked source's queue
               q = 2 * j + mon_src[j];
               if (exp_flit[q].size() == 0) begin
                  $display("output %0d sent a flit from input %0d beyond what was expected",
                           j, mon_src[j]);
                  abort_run();
               end else begin
                  mon_cnt[j] = mon_cnt[j] + 1'b1;
                  if (got.last) begin
                     // flits framed by the port itself against the case length
                     cn = exp_case[q].pop_front();
                     check_len($sformatf("length of case %0d on out_flit[%0d]", cn, j),
                               exp_len[q].pop_front(), mon_cnt[j]);
                     mon_busy[j] = 1'b0;
                  end
                  check_flit($sformatf("out_flit[%0d]", j), exp_flit[q].pop_front(), got);
               end
            end
         end
         // input side runs last so a last flit counts only from the next edge on
         for (i = 0; i < 2; i++) begin
            if (in_valid[i] && in_ready[i]) begin
               if (in_hdr[i]) begin
                  in_out[i] = out_port(in_flit[i].data.hdr.dest);
               end
               in_hdr[i] = in_flit[i].last;
               if (in_flit[i].last) begin
                  pkt_in[2*in_out[i] + i]++;
               end
            end
         end
      end
   end

   initial begin
      int c;
      int waited;
      rst = 1'b1;
      for (c = 0; c < 2; c++) begin
         drv_flit[c]  = '0;
         drv_valid[c] = 1'b0;
      end
      load_cases();

      // four edges under reset and one quiet cycle after
      for (c = 0; c < 4; c++) begin
         @(posedge clk);
         #1;
         if (c == 3) begin
            rst = 1'b0;
         end
         @(negedge clk);
         expect_bits("out_valid", 2'b00, out_valid);
         expect_bits("in_ready", 2'b11, in_ready);
      end
      @(posedge clk);
      #1;
      @(negedge clk);
      expect_bits("out_valid", 2'b00, out_valid);
      expect_bits("in_ready", 2'b11, in_ready);

      @(posedge clk);
      #1;
      stall_mode = 1;
      fork
         send_packets(0);
         send_packets(1);
      join

      waited = 0;
      while (!all_drained()) begin
         @(posedge clk);
         waited++;
         if (waited > DRAIN_LIMIT) begin
            report_missing();
            abort_run();
         end
      end

      // any stray flit now trips the monitor
      stall_mode = 2;
      repeat (20) @(posedge clk);
      $display("Simulation PASSED");
      $finish;
   end

endmodule
